/* logic/alu.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module alu (
    input  alu_pkg::alu_fun_t fun,
    input  alu_pkg::word_t    op1,
    input  alu_pkg::word_t    op2,
    output alu_pkg::word_t    result
);
    import alu_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt;
    logic               ltu;

    assign shamt = op2[SHAMT_W-1:0];   // rv32 uses the low five bits
    assign lt    = $signed(op1) < $signed(op2);
    assign ltu   = op1 < op2;

    always_comb begin
        case (fun)
            ADD: begin
                result = op1 + op2;
            end
            SUB: begin
                result = op1 - op2;
            end
            SLL: begin
                result = op1 << shamt;
            end
            SLT: begin
                result = word_t'(lt);   // zero extended flag
            end
            SLTU: begin
                result = word_t'(ltu);
            end
            XOR: begin
                result = op1 ^ op2;
            end
            SRL: begin
                result = op1 >> shamt;
            end
            SRA: begin
                result = word_t'($signed(op1) >>> shamt);
            end
            OR: begin
                result = op1 | op2;
            end
            AND: begin
                result = op1 & op2;
            end
            PASS2: begin
                result = op2;   // lui immediate
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // decode must never hand over a code outside the enum
    always_comb begin
        if (!$isunknown(fun)) begin
            assert (fun inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS2})
                else $error("alu: unknown function code %0h", fun);
        end
    end

endmodule

/* logic/alu_pkg.sv */
`include "rv_consts.svh"

package alu_pkg;

    // one machine word, used for operands, pc and results
    typedef logic [`XLEN-1:0] word_t;

    // alu function select as produced by decode
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,   // signed compare
        SLTU  = 4'd4,   // unsigned compare
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,   // sign fill
        OR    = 4'd8,
        AND   = 4'd9,
        PASS2 = 4'd10   // op2 straight through, for lui
    } alu_fun_t;

endpackage

/* logic/branch_unit.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module branch_unit (
    input  ctrl_pkg::jmp_t jmp,
    input  alu_pkg::word_t rs1,
    input  alu_pkg::word_t rs2,
    input  alu_pkg::word_t pc,
    input  alu_pkg::word_t alu_result,
    output logic           taken,
    output alu_pkg::word_t target
);
    import alu_pkg::*;
    import ctrl_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    // register comparisons
    assign eq  = rs1 == rs2;
    assign lt  = $signed(rs1) < $signed(rs2);
    assign ltu = rs1 < rs2;

    always_comb begin
        case (jmp)
            JAL_OR_JALR: begin
                taken = 1'b1;
            end
            BEQ: begin
                taken = eq;
            end
            BNE: begin
                taken = !eq;
            end
            BLT: begin
                taken = lt;
            end
            BGE: begin
                taken = !lt;   // greater or equal, signed
            end
            BLTU: begin
                taken = ltu;
            end
            BGEU: begin
                taken = !ltu;
            end
            default: begin
                taken = 1'b0;   // no control transfer
            end
        endcase
    end

    // alu already computed pc+imm or rs1+imm
    assign target = taken ? alu_result : pc + word_t'(`PC_STEP);

endmodule

/* logic/ctrl_pkg.sv */
package ctrl_pkg;

    // control transfer kind carried with each instruction
    typedef enum logic [2:0] {
        NONE        = 3'd0,
        JAL_OR_JALR = 3'd1,   // unconditional, target from alu
        BEQ         = 3'd2,
        BNE         = 3'd3,
        BLT         = 3'd4,
        BGE         = 3'd5,
        BLTU        = 3'd6,
        BGEU        = 3'd7
    } jmp_t;

    // memory stage operation
    typedef enum logic [1:0] {
        NULL  = 2'd0,   // no memory access
        LOAD  = 2'd1,
        STORE = 2'd2
    } mem_op_t;

endpackage

/* logic/execute.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module execute (
    input  logic                down,
    input  logic                rst_n,

    input  logic                in_valid,
    output logic                in_ready,
    input  alu_pkg::alu_fun_t   in_fun,
    input  ctrl_pkg::jmp_t      in_jmp,
    input  ctrl_pkg::mem_op_t   in_mem_op,
    input  alu_pkg::word_t      in_pc,
    input  alu_pkg::word_t      in_op1,
    input  alu_pkg::word_t      in_op2,
    input  alu_pkg::word_t      in_rs1,
    input  alu_pkg::word_t      in_rs2,
    input  logic [`REG_AW-1:0]  in_rd,

    output logic                branch,
    output alu_pkg::word_t      target,
    output alu_pkg::word_t      bypass,

    output logic                out_valid,
    input  logic                out_ready,
    output ctrl_pkg::mem_op_t   out_mem_op,
    output ctrl_pkg::jmp_t      out_jmp,
    output logic [`REG_AW-1:0]  out_rd,
    output alu_pkg::word_t      out_result,
    output alu_pkg::word_t      out_store_data
);
    import alu_pkg::*;
    import ctrl_pkg::*;

    word_t alu_result;
    word_t link_pc;
    logic  accept;

    // register slot is free when empty or draining this cycle
    assign in_ready = out_ready || !out_valid;
    assign accept   = in_valid && in_ready;
    assign link_pc  = in_pc + word_t'(`PC_STEP);
    assign bypass   = alu_result;   // raw result for forwarding

    alu u_alu (
        .fun    (in_fun),
        .op1    (in_op1),
        .op2    (in_op2),
        .result (alu_result)
    );

    branch_unit u_branch_unit (
        .jmp        (in_jmp),
        .rs1        (in_rs1),
        .rs2        (in_rs2),
        .pc         (in_pc),
        .alu_result (alu_result),
        .taken      (branch),
        .target     (target)
    );

    always_ff @(posedge down or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_mem_op <= NULL;
            out_jmp    <= NONE;
            out_rd     <= '0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;   // drops to a bubble if nothing comes in
            end
            if (accept) begin
                out_mem_op <= in_mem_op;
                out_jmp    <= in_jmp;
                out_rd     <= in_rd;
            end
        end
    end

    // payload, qualified by out_valid downstream
    always_ff @(posedge down) begin
        if (accept) begin
            out_result     <= (in_jmp == JAL_OR_JALR) ? link_pc : alu_result;   // link value
            out_store_data <= in_rs2;
        end
    end

    assert property (@(posedge down) disable iff (!rst_n)
        !$isunknown(out_valid))
        else $error("execute: out_valid unknown");

    // a stalled bundle must not change until memory stage takes it
    assert property (@(posedge down) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid
            && $stable(out_mem_op) && $stable(out_jmp) && $stable(out_rd)
            && $stable(out_result) && $stable(out_store_data))
        else $error("execute: output changed while stalled");

endmodule

/* logic/execute_top.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module execute_top (
    input  logic                down,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  alu_pkg::alu_fun_t   in_fun,
    input  ctrl_pkg::jmp_t      in_jmp,
    input  ctrl_pkg::mem_op_t   in_mem_op,
    input  alu_pkg::word_t      in_pc,
    input  alu_pkg::word_t      in_op1,
    input  alu_pkg::word_t      in_op2,
    input  alu_pkg::word_t      in_rs1,
    input  alu_pkg::word_t      in_rs2,
    input  logic [`REG_AW-1:0]  in_rd,
    output logic                branch,
    output alu_pkg::word_t      target,
    output alu_pkg::word_t      bypass,
    output logic                out_valid,
    input  logic                out_ready,
    output ctrl_pkg::mem_op_t   out_mem_op,
    output ctrl_pkg::jmp_t      out_jmp,
    output logic [`REG_AW-1:0]  out_rd,
    output alu_pkg::word_t      out_result,
    output alu_pkg::word_t      out_store_data
);

    execute u_execute (
        .down           (down),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_fun         (in_fun),
        .in_jmp         (in_jmp),
        .in_mem_op      (in_mem_op),
        .in_pc          (in_pc),
        .in_op1         (in_op1),
        .in_op2         (in_op2),
        .in_rs1         (in_rs1),
        .in_rs2         (in_rs2),
        .in_rd          (in_rd),
        .branch         (branch),
        .target         (target),
        .bypass         (bypass),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_mem_op     (out_mem_op),
        .out_jmp        (out_jmp),
        .out_rd         (out_rd),
        .out_result     (out_result),
        .out_store_data (out_store_data)
    );

endmodule

/* logic/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// width of the integer data path
`define XLEN 32

// register file address width, x0..x31
`define REG_AW 5

// pc increment for the link value and the not-taken path
`define PC_STEP 4

`endif

/* project.f */
+incdir+logic
logic/alu_pkg.sv
logic/ctrl_pkg.sv
logic/alu.sv
logic/branch_unit.sv
logic/execute.sv
logic/execute_top.sv
verif/tb_clock.sv
verif/execute_checker.sv
verif/tb_execute.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_execute \
    -f project.f --Mdir obj_dir -o sim_execute
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_execute)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verif/execute_checker.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module execute_checker (
    input  logic                down,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                in_ready,
    input  ctrl_pkg::mem_op_t   in_mem_op,
    input  ctrl_pkg::jmp_t      in_jmp,
    input  logic [`REG_AW-1:0]  in_rd,
    input  logic                branch,
    input  alu_pkg::word_t      target,
    input  alu_pkg::word_t      bypass,
    input  logic                out_valid,
    input  logic                out_ready,
    input  ctrl_pkg::mem_op_t   out_mem_op,
    input  ctrl_pkg::jmp_t      out_jmp,
    input  logic [`REG_AW-1:0]  out_rd,
    input  alu_pkg::word_t      out_result,
    input  alu_pkg::word_t      out_store_data,
    input  alu_pkg::word_t      exp_result,
    input  logic                exp_branch,
    input  alu_pkg::word_t      exp_target,
    input  alu_pkg::word_t      exp_bypass,
    input  alu_pkg::word_t      exp_store_data,
    output int                  tests_done,
    output int                  tests_failed,
    output int                  error_count
);
    import alu_pkg::*;
    import ctrl_pkg::*;

    typedef struct packed {
        int                 idx;
        int                 errs;   // mismatches seen at acceptance
        mem_op_t            mem_op;
        jmp_t               jmp;
        logic [`REG_AW-1:0] rd;
        word_t              result;
        word_t              store_data;
    } expect_t;

    expect_t            pending [$];   // accepted and not yet at the output
    int                 done_count    = 0;
    int                 failed_count  = 0;
    int                 err_count     = 0;
    int                 accept_idx    = 0;
    int                 cur_errs      = 0;
    bit                 reset_checked = 1'b0;
    bit                 stalled       = 1'b0;
    mem_op_t            hold_mem_op;
    jmp_t               hold_jmp;
    logic [`REG_AW-1:0] hold_rd;
    word_t              hold_result;
    word_t              hold_store_data;

    assign tests_done   = done_count;
    assign tests_failed = failed_count;
    assign error_count  = err_count;

    task automatic compare_word(input string label, input string name,
                                input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s %s is %08h, expected %08h", label, name, got, exp);
            cur_errs++;
            err_count++;
        end
    endtask

    task automatic inspect_reset_state();
        int errs_before;
        errs_before = err_count;
        compare_word("reset", "out_valid", 32'(out_valid), 32'd0);
        compare_word("reset", "out_mem_op", 32'(out_mem_op), 32'(NULL));
        compare_word("reset", "out_jmp", 32'(out_jmp), 32'(NONE));
        compare_word("reset", "out_rd", 32'(out_rd), 32'd0);
        if (err_count == errs_before) begin
            $display("reset state ok");
        end else begin
            $display("reset state wrong");
        end
        reset_checked = 1'b1;
    endtask

    // upstream may send whenever the output slot is empty or draining
    task automatic audit_in_ready();
        logic ready_exp;
        ready_exp = out_ready === 1'b1 || out_valid !== 1'b1;
        compare_word("handshake", "in_ready", 32'(in_ready), 32'(ready_exp));
    endtask

    // a stalled bundle must look the same one cycle later
    task automatic confirm_stall_hold();
        if (stalled) begin
            compare_word("stall", "out_valid", 32'(out_valid), 32'd1);
            compare_word("stall", "out_mem_op", 32'(out_mem_op), 32'(hold_mem_op));
            compare_word("stall", "out_jmp", 32'(out_jmp), 32'(hold_jmp));
            compare_word("stall", "out_rd", 32'(out_rd), 32'(hold_rd));
            compare_word("stall", "out_result", out_result, hold_result);
            compare_word("stall", "out_store_data", out_store_data, hold_store_data);
        end
        stalled         = out_valid === 1'b1 && out_ready !== 1'b1;
        hold_mem_op     = out_mem_op;
        hold_jmp        = out_jmp;
        hold_rd         = out_rd;
        hold_result     = out_result;
        hold_store_data = out_store_data;
    endtask

    task automatic score_output();
        expect_t e;
        string   label;
        if (out_valid === 1'b1 && out_ready === 1'b1) begin
            if (pending.size() == 0) begin
                $display("output bundle appeared with no instruction outstanding");
                err_count++;
            end else begin
                e        = pending.pop_front();
                label    = $sformatf("test %0d", e.idx);
                cur_errs = e.errs;
                compare_word(label, "out_mem_op", 32'(out_mem_op), 32'(e.mem_op));
                compare_word(label, "out_jmp", 32'(out_jmp), 32'(e.jmp));
                compare_word(label, "out_rd", 32'(out_rd), 32'(e.rd));
                compare_word(label, "out_result", out_result, e.result);
                compare_word(label, "out_store_data", out_store_data, e.store_data);
                done_count++;
                if (cur_errs == 0) begin
                    $display("test %0d ok, result %08h", e.idx, out_result);
                end else begin
                    $display("test %0d wrong in %0d fields", e.idx, cur_errs);
                    failed_count++;
                end
            end
        end
    endtask

    // branch, target and bypass only hold while the bundle is at the input
    task automatic record_accept();
        expect_t e;
        string   label;
        if (in_valid === 1'b1 && in_ready === 1'b1) begin
            label    = $sformatf("test %0d", accept_idx);
            cur_errs = 0;
            compare_word(label, "branch", 32'(branch), 32'(exp_branch));
            compare_word(label, "target", target, exp_target);
            compare_word(label, "bypass", bypass, exp_bypass);
            e.idx        = accept_idx;
            e.errs       = cur_errs;
            e.mem_op     = in_mem_op;
            e.jmp        = in_jmp;
            e.rd         = in_rd;
            e.result     = exp_result;
            e.store_data = exp_store_data;
            pending.push_back(e);
            accept_idx++;
        end
    endtask

    // sampled on the falling edge halfway between drive edges
    always @(negedge down) begin
        if (rst_n === 1'b1) begin
            if (!reset_checked) begin
                inspect_reset_state();
            end
            audit_in_ready();
            confirm_stall_hold();
            score_output();
            record_accept();
        end
    end

endmodule

/* verif/execute_patterns.hex */
// fun jmp mem_op pc op1 op2 rs1 rs2 rd, then expected result branch target bypass store_data
// enum codes as in alu_pkg and ctrl_pkg, one instruction per row
0 0 0 00001000 00000005 00000007 00000005 00000007 01 0000000c 0 00001004 0000000c 00000007
0 0 1 00001004 ffffffff 00000002 ffffffff 00000002 02 00000001 0 00001008 00000001 00000002
1 0 0 00001008 00000003 00000005 00000003 00000005 03 fffffffe 0 0000100c fffffffe 00000005
2 0 0 0000100c 00000001 0000001f 00000001 0000001f 04 80000000 0 00001010 80000000 0000001f
2 0 0 00001010 0000000f 00000024 0000000f 00000024 05 000000f0 0 00001014 000000f0 00000024
3 0 0 00001014 ffffffff 00000001 ffffffff 00000001 06 00000001 0 00001018 00000001 00000001
4 0 0 00001018 ffffffff 00000001 ffffffff 00000001 07 00000000 0 0000101c 00000000 00000001
3 0 0 0000101c 00000005 00000003 00000005 00000003 08 00000000 0 00001020 00000000 00000003
4 0 0 00001020 00000003 80000000 00000003 80000000 09 00000001 0 00001024 00000001 80000000
5 0 0 00001024 ff00ff00 0f0f0f0f ff00ff00 0f0f0f0f 0a f00ff00f 0 00001028 f00ff00f 0f0f0f0f
6 0 0 00001028 80000000 00000004 80000000 00000004 0b 08000000 0 0000102c 08000000 00000004
7 0 0 0000102c 80000000 00000004 80000000 00000004 0c f8000000 0 00001030 f8000000 00000004
7 0 0 00001030 7ffffff0 00000004 7ffffff0 00000004 0d 07ffffff 0 00001034 07ffffff 00000004
8 0 1 00001034 12340000 00005678 12340000 00005678 0e 12345678 0 00001038 12345678 00005678
9 0 0 00001038 f0f0f0f0 ff00ff00 f0f0f0f0 ff00ff00 0f f000f000 0 0000103c f000f000 ff00ff00
a 0 0 0000103c deadbeef abcde000 deadbeef abcde000 10 abcde000 0 00001040 abcde000 abcde000
0 0 2 00001040 00002000 00000010 00002000 cafef00d 00 00002010 0 00001044 00002010 cafef00d
0 2 0 00001044 00001044 00000100 00000007 00000007 00 00001144 1 00001144 00001144 00000007
0 2 0 00001048 00001048 00000100 00000009 00000003 00 00001148 0 0000104c 00001148 00000003
0 3 0 0000104c 0000104c 00000100 00000007 00000007 00 0000114c 0 00001050 0000114c 00000007
0 3 0 00001050 00001050 00000100 00000003 00000009 00 00001150 1 00001150 00001150 00000009
0 4 0 00001054 00001054 00000100 00000007 00000007 00 00001154 0 00001058 00001154 00000007
0 4 0 00001058 00001058 00000100 00000003 00000009 00 00001158 1 00001158 00001158 00000009
0 4 0 0000105c 0000105c 00000100 00000009 00000003 00 0000115c 0 00001060 0000115c 00000003
0 4 0 00001060 00001060 00000100 ffffffff 00000001 00 00001160 1 00001160 00001160 00000001
0 5 0 00001064 00001064 00000100 00000007 00000007 00 00001164 1 00001164 00001164 00000007
0 5 0 00001068 00001068 00000100 00000003 00000009 00 00001168 0 0000106c 00001168 00000009
0 5 0 0000106c 0000106c 00000100 ffffffff 00000001 00 0000116c 0 00001070 0000116c 00000001
0 5 0 00001070 00001070 00000100 00000001 ffffffff 00 00001170 1 00001170 00001170 ffffffff
0 6 0 00001074 00001074 00000100 00000007 00000007 00 00001174 0 00001078 00001174 00000007
0 6 0 00001078 00001078 00000100 ffffffff 00000001 00 00001178 0 0000107c 00001178 00000001
0 6 0 0000107c 0000107c 00000100 00000001 ffffffff 00 0000117c 1 0000117c 0000117c ffffffff
0 7 0 00001080 00001080 00000100 00000007 00000007 00 00001180 1 00001180 00001180 00000007
0 7 0 00001084 00001084 00000100 00000003 00000009 00 00001184 0 00001088 00001184 00000009
0 7 0 00001088 00001088 00000100 ffffffff 00000001 00 00001188 1 00001188 00001188 00000001
0 1 0 0000108c 0000108c fffffff0 00000000 00000000 01 00001090 1 0000107c 0000107c 00000000
0 1 0 00001090 00003000 00000008 00003000 00000000 05 00001094 1 00003008 00003008 00000000

/* verif/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic down,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 4;   // 8 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        down = 1'b0;
        forever begin
            #HALF_PERIOD down = ~down;
        end
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge down);
        rst_n <= 1'b1;   // released on a rising edge
    end

endmodule

/* verif/tb_execute.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_execute;
    import alu_pkg::*;
    import ctrl_pkg::*;

    localparam int NUM_PATTERNS    = 37;
    localparam int ROW_WORDS       = 14;   // 9 stimulus and 5 expected words
    localparam int CYCLES_PER_TEST = 40;
    localparam int RAND_SEED       = 92768;

    logic               down;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    alu_fun_t           in_fun;
    jmp_t               in_jmp;
    mem_op_t            in_mem_op;
    word_t              in_pc;
    word_t              in_op1;
    word_t              in_op2;
    word_t              in_rs1;
    word_t              in_rs2;
    logic [`REG_AW-1:0] in_rd;
    logic               branch;
    word_t              target;
    word_t              bypass;
    logic               out_valid;
    logic               out_ready;
    mem_op_t            out_mem_op;
    jmp_t               out_jmp;
    logic [`REG_AW-1:0] out_rd;
    word_t              out_result;
    word_t              out_store_data;
    word_t              exp_result;
    logic               exp_branch;
    word_t              exp_target;
    word_t              exp_bypass;
    word_t              exp_store_data;
    int                 tests_done;
    int                 tests_failed;
    int                 error_count;
    logic [31:0]        patterns [0:NUM_PATTERNS*ROW_WORDS-1];

    tb_clock u_clock (
        .down  (down),
        .rst_n (rst_n)
    );

    execute_top dut0 (
        .down (down), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready),
        .in_fun (in_fun), .in_jmp (in_jmp), .in_mem_op (in_mem_op),
        .in_pc (in_pc), .in_op1 (in_op1), .in_op2 (in_op2),
        .in_rs1 (in_rs1), .in_rs2 (in_rs2), .in_rd (in_rd),
        .branch (branch), .target (target), .bypass (bypass),
        .out_valid (out_valid), .out_ready (out_ready),
        .out_mem_op (out_mem_op), .out_jmp (out_jmp), .out_rd (out_rd),
        .out_result (out_result), .out_store_data (out_store_data)
    );

    execute_checker u_checker (
        .down (down), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready),
        .in_mem_op (in_mem_op), .in_jmp (in_jmp), .in_rd (in_rd),
        .branch (branch), .target (target), .bypass (bypass),
        .out_valid (out_valid), .out_ready (out_ready),
        .out_mem_op (out_mem_op), .out_jmp (out_jmp), .out_rd (out_rd),
        .out_result (out_result), .out_store_data (out_store_data),
        .exp_result (exp_result), .exp_branch (exp_branch),
        .exp_target (exp_target), .exp_bypass (exp_bypass),
        .exp_store_data (exp_store_data),
        .tests_done (tests_done), .tests_failed (tests_failed),
        .error_count (error_count)
    );

    task automatic drive_row(input int row);
        int base;
        base = row * ROW_WORDS;
        in_valid       <= 1'b1;
        in_fun         <= alu_fun_t'(patterns[base][3:0]);
        in_jmp         <= jmp_t'(patterns[base + 1][2:0]);
        in_mem_op      <= mem_op_t'(patterns[base + 2][1:0]);
        in_pc          <= patterns[base + 3];
        in_op1         <= patterns[base + 4];
        in_op2         <= patterns[base + 5];
        in_rs1         <= patterns[base + 6];
        in_rs2         <= patterns[base + 7];
        in_rd          <= patterns[base + 8][`REG_AW-1:0];
        exp_result     <= patterns[base + 9];
        exp_branch     <= patterns[base + 10][0];
        exp_target     <= patterns[base + 11];
        exp_bypass     <= patterns[base + 12];
        exp_store_data <= patterns[base + 13];
    endtask

    // returns on the edge that takes the bundle
    task automatic wait_accept();
        @(negedge down);
        while (in_ready !== 1'b1) begin
            @(negedge down);
        end
        @(posedge down);
    endtask

    initial begin
        in_valid       <= 1'b0;
        in_fun         <= ADD;
        in_jmp         <= NONE;
        in_mem_op      <= NULL;
        in_pc          <= '0;
        in_op1         <= '0;
        in_op2         <= '0;
        in_rs1         <= '0;
        in_rs2         <= '0;
        in_rd          <= '0;
        exp_result     <= '0;
        exp_branch     <= 1'b0;
        exp_target     <= '0;
        exp_bypass     <= '0;
        exp_store_data <= '0;
        $readmemh("verif/execute_patterns.hex", patterns);
        wait (rst_n === 1'b1);
        @(posedge down);
        for (int i = 0; i < NUM_PATTERNS; i++) begin
            drive_row(i);
            wait_accept();
        end
        in_valid <= 1'b0;
        wait (tests_done == NUM_PATTERNS);
        @(posedge down);
        $display("%0d of %0d tests done, %0d failed, %0d errors",
                 tests_done, NUM_PATTERNS, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // random back-pressure from the memory stage
    initial begin
        void'($urandom(RAND_SEED));
        out_ready <= 1'b0;
        forever begin
            @(posedge down);
            out_ready <= ($urandom % 2) != 0;
        end
    end

    initial begin
        repeat (NUM_PATTERNS * CYCLES_PER_TEST) @(posedge down);
        $display("timeout: only %0d of %0d tests reached the output", tests_done, NUM_PATTERNS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
